/* rtl/udp_pkg.sv */
// UDP header constants and the UDP header union
package udp_pkg;

    localparam int UDP_HDR_BYTES = 8;
    localparam int LEN_WIDTH     = 16;
    localparam int PORT_WIDTH    = 16;

    // Header as named fields or as bytes in wire order, byte 0 first
    typedef union packed {
        struct packed {
            logic [PORT_WIDTH-1:0] source_port;
            logic [PORT_WIDTH-1:0] dest_port;
            logic [LEN_WIDTH-1:0]  length;
            logic [15:0]           checksum;
        } fields;
        logic [0:UDP_HDR_BYTES-1][7:0] bytes;
    } udp_hdr_u;

endpackage

/* rtl/byte_fifo.sv */
// Synchronous byte FIFO carrying a last flag with each byte
module byte_fifo #(
    parameter int DEPTH = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    input  logic       in_last,
    output logic       in_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    input  logic       out_ready
);

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);

    logic [8:0]        mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_write;
    logic              do_read;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign do_write  = in_valid && in_ready;
    assign do_read   = out_valid && out_ready;

    // Head entry shows as soon as it is written
    assign {out_last, out_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= {in_last, in_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_write) - CNT_W'(do_read);
        end
    end

endmodule

/* rtl/udp_rx_filter.sv */
// UDP header parser and destination port filter for received datagrams
module udp_rx_filter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [udp_pkg::PORT_WIDTH-1:0] rx_dest_port,
    input  logic [7:0]                     rx_data,
    input  logic                           rx_valid,
    input  logic                           rx_last,
    output logic                           rx_ready,
    output logic [7:0]                     fifo_in_data,
    output logic                           fifo_in_valid,
    output logic                           fifo_in_last,
    input  logic                           fifo_in_ready
);
    import udp_pkg::*;

    localparam int HDR_CNT_W = $clog2(UDP_HDR_BYTES + 1);
    localparam int HDR_IDX_W = $clog2(UDP_HDR_BYTES);

    logic [HDR_CNT_W-1:0] hdr_cnt;
    logic                 in_header;
    logic                 match;
    logic                 rx_accept;
    udp_hdr_u             hdr;

    assign in_header = (hdr_cnt < HDR_CNT_W'(UDP_HDR_BYTES));

    // Matched payload goes straight to the FIFO, so it sets back-pressure
    assign rx_ready      = (in_header || !match) ? 1'b1 : fifo_in_ready;
    assign rx_accept     = rx_valid && rx_ready;
    assign fifo_in_data  = rx_data;
    assign fifo_in_last  = rx_last;
    assign fifo_in_valid = rx_valid && !in_header && match;

    // Header bytes land by position in wire order
    always_ff @(posedge clk) begin
        if (rx_accept && in_header) begin
            hdr.bytes[hdr_cnt[HDR_IDX_W-1:0]] <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_cnt <= '0;
            match   <= 1'b0;
        end else if (rx_accept) begin
            if (rx_last) begin
                // Also drops a datagram cut short inside its header
                hdr_cnt <= '0;
                match   <= 1'b0;
            end else if (in_header) begin
                hdr_cnt <= hdr_cnt + 1'b1;
                if (hdr_cnt == HDR_CNT_W'(UDP_HDR_BYTES - 1)) begin
                    // Port bytes 2 and 3 are already stored here
                    match <= (hdr.fields.dest_port == rx_dest_port);
                end
            end
        end
    end

endmodule

/* rtl/tx_frame_buffer.sv */
// TX payload buffer releasing only complete frames, with a frame length queue
module tx_frame_buffer #(
    parameter int DEPTH      = 256,
    parameter int MAX_FRAMES = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [7:0]                    in_data,
    input  logic                          in_valid,
    input  logic                          in_last,
    output logic                          in_ready,
    output logic [udp_pkg::LEN_WIDTH-1:0] frame_len,
    output logic                          frame_len_valid,
    input  logic                          frame_len_ready,
    output logic [7:0]                    buf_data,
    output logic                          buf_valid,
    output logic                          buf_last,
    input  logic                          buf_ready
);
    import udp_pkg::*;

    localparam int ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int QADDR_W = (MAX_FRAMES > 1) ? $clog2(MAX_FRAMES) : 1;
    localparam int QCNT_W  = $clog2(MAX_FRAMES + 1);

    logic [8:0]           mem [DEPTH];
    logic [ADDR_W-1:0]    wr_ptr;
    logic [ADDR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]     fill;
    logic [CNT_W-1:0]     committed;
    logic [LEN_WIDTH-1:0] cur_len;
    logic [LEN_WIDTH-1:0] next_len;
    logic [LEN_WIDTH-1:0] len_q [MAX_FRAMES];
    logic [QADDR_W-1:0]   len_wr;
    logic [QADDR_W-1:0]   len_rd;
    logic [QCNT_W-1:0]    len_cnt;
    logic                 do_write;
    logic                 do_read;
    logic                 frame_end;
    logic                 len_pop;

    assign in_ready  = (fill != CNT_W'(DEPTH)) && (len_cnt != QCNT_W'(MAX_FRAMES));
    assign do_write  = in_valid && in_ready;
    assign frame_end = do_write && in_last;
    assign next_len  = cur_len + 1'b1;

    // Only bytes of finished frames are visible downstream
    assign buf_valid = (committed != '0);
    assign {buf_last, buf_data} = mem[rd_ptr];
    assign do_read   = buf_valid && buf_ready;

    assign frame_len       = len_q[len_rd];
    assign frame_len_valid = (len_cnt != '0);
    assign len_pop         = frame_len_valid && frame_len_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= {in_last, in_data};
        end
        if (frame_end) begin
            len_q[len_wr] <= next_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            committed <= '0;
            cur_len   <= '0;
            len_wr    <= '0;
            len_rd    <= '0;
            len_cnt   <= '0;
        end else begin
            if (do_write) begin
                wr_ptr  <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                cur_len <= in_last ? '0 : next_len;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + CNT_W'(do_write) - CNT_W'(do_read);

            // Whole frame becomes readable on its last byte
            committed <= committed + (frame_end ? CNT_W'(next_len) : CNT_W'(0))
                         - CNT_W'(do_read);

            if (frame_end) begin
                len_wr <= (len_wr == QADDR_W'(MAX_FRAMES - 1)) ? '0 : len_wr + 1'b1;
            end
            if (len_pop) begin
                len_rd <= (len_rd == QADDR_W'(MAX_FRAMES - 1)) ? '0 : len_rd + 1'b1;
            end
            len_cnt <= len_cnt + QCNT_W'(frame_end) - QCNT_W'(len_pop);
        end
    end

endmodule

/* rtl/udp_tx_framer.sv */
// UDP header builder and serializer followed by payload pass-through
module udp_tx_framer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [udp_pkg::PORT_WIDTH-1:0] tx_source_port,
    input  logic [udp_pkg::PORT_WIDTH-1:0] tx_dest_port,
    input  logic [udp_pkg::LEN_WIDTH-1:0]  frame_len,
    input  logic                           frame_len_valid,
    output logic                           frame_len_ready,
    input  logic [7:0]                     buf_data,
    input  logic                           buf_valid,
    input  logic                           buf_last,
    output logic                           buf_ready,
    output logic [7:0]                     tx_out,
    output logic                           tx_valid,
    output logic                           tx_last,
    input  logic                           tx_ready
);
    import udp_pkg::*;

    localparam int IDX_W = $clog2(UDP_HDR_BYTES);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HEADER  = 2'd1;
    localparam logic [1:0] ST_PAYLOAD = 2'd2;

    logic [1:0]       state;
    logic [IDX_W-1:0] byte_idx;
    udp_hdr_u         hdr;

    assign frame_len_ready = (state == ST_IDLE);

    always_comb begin
        tx_out    = hdr.bytes[byte_idx];
        tx_valid  = 1'b0;
        tx_last   = 1'b0;
        buf_ready = 1'b0;
        case (state)
            ST_HEADER: begin
                tx_valid = 1'b1;
            end
            ST_PAYLOAD: begin
                tx_out    = buf_data;
                tx_valid  = buf_valid;
                tx_last   = buf_last;
                buf_ready = tx_ready;
            end
            default: begin
                tx_valid = 1'b0;
            end
        endcase
    end

    // Header fields are latched once per frame
    always_ff @(posedge clk) begin
        if (frame_len_valid && frame_len_ready) begin
            hdr.fields.source_port <= tx_source_port;
            hdr.fields.dest_port   <= tx_dest_port;
            hdr.fields.length      <= frame_len + LEN_WIDTH'(UDP_HDR_BYTES);
            hdr.fields.checksum    <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            byte_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_len_valid) begin
                        state    <= ST_HEADER;
                        byte_idx <= '0;
                    end
                end
                ST_HEADER: begin
                    if (tx_ready) begin
                        if (byte_idx == IDX_W'(UDP_HDR_BYTES - 1)) begin
                            state <= ST_PAYLOAD;
                        end
                        byte_idx <= byte_idx + 1'b1;
                    end
                end
                ST_PAYLOAD: begin
                    if (tx_ready && buf_valid && buf_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/udp_connection.sv */
// UDP endpoint top level with receive filter and FIFO, transmit buffer and framer
module udp_connection #(
    parameter int RX_FIFO_DEPTH = 64,
    parameter int TX_FIFO_DEPTH = 256,
    parameter int TX_MAX_FRAMES = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [udp_pkg::PORT_WIDTH-1:0] rx_dest_port,
    input  logic [udp_pkg::PORT_WIDTH-1:0] tx_source_port,
    input  logic [udp_pkg::PORT_WIDTH-1:0] tx_dest_port,
    input  logic [7:0]                     rx_data,
    input  logic                           rx_valid,
    input  logic                           rx_last,
    output logic                           rx_ready,
    output logic [7:0]                     rx_data_out,
    output logic                           rx_data_valid,
    output logic                           rx_data_last,
    input  logic                           rx_data_ready,
    input  logic [7:0]                     tx_data,
    input  logic                           tx_data_valid,
    input  logic                           tx_data_last,
    output logic                           tx_data_ready,
    output logic [7:0]                     tx_out,
    output logic                           tx_valid,
    output logic                           tx_last,
    input  logic                           tx_ready
);
    import udp_pkg::*;

    logic [7:0]           fifo_in_data;
    logic                 fifo_in_valid;
    logic                 fifo_in_last;
    logic                 fifo_in_ready;
    logic [LEN_WIDTH-1:0] frame_len;
    logic                 frame_len_valid;
    logic                 frame_len_ready;
    logic [7:0]           buf_data;
    logic                 buf_valid;
    logic                 buf_last;
    logic                 buf_ready;

    // Receive path
    udp_rx_filter i_rx_filter (
        .clk           (clk),
        .rst           (rst),
        .rx_dest_port  (rx_dest_port),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .rx_last       (rx_last),
        .rx_ready      (rx_ready),
        .fifo_in_data  (fifo_in_data),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_last  (fifo_in_last),
        .fifo_in_ready (fifo_in_ready)
    );

    byte_fifo #(
        .DEPTH (RX_FIFO_DEPTH)
    ) i_rx_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (fifo_in_data),
        .in_valid  (fifo_in_valid),
        .in_last   (fifo_in_last),
        .in_ready  (fifo_in_ready),
        .out_data  (rx_data_out),
        .out_valid (rx_data_valid),
        .out_last  (rx_data_last),
        .out_ready (rx_data_ready)
    );

    // Transmit path
    tx_frame_buffer #(
        .DEPTH      (TX_FIFO_DEPTH),
        .MAX_FRAMES (TX_MAX_FRAMES)
    ) i_tx_buffer (
        .clk             (clk),
        .rst             (rst),
        .in_data         (tx_data),
        .in_valid        (tx_data_valid),
        .in_last         (tx_data_last),
        .in_ready        (tx_data_ready),
        .frame_len       (frame_len),
        .frame_len_valid (frame_len_valid),
        .frame_len_ready (frame_len_ready),
        .buf_data        (buf_data),
        .buf_valid       (buf_valid),
        .buf_last        (buf_last),
        .buf_ready       (buf_ready)
    );

    udp_tx_framer i_tx_framer (
        .clk             (clk),
        .rst             (rst),
        .tx_source_port  (tx_source_port),
        .tx_dest_port    (tx_dest_port),
        .frame_len       (frame_len),
        .frame_len_valid (frame_len_valid),
        .frame_len_ready (frame_len_ready),
        .buf_data        (buf_data),
        .buf_valid       (buf_valid),
        .buf_last        (buf_last),
        .buf_ready       (buf_ready),
        .tx_out          (tx_out),
        .tx_valid        (tx_valid),
        .tx_last         (tx_last),
        .tx_ready        (tx_ready)
    );

endmodule

/* test/tb_udp_connection.sv */
// Testbench for udp_connection with stimulus file reader, drivers, output checkers and timeout
module tb_udp_connection;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic [15:0] rx_dest_port;
    logic [15:0] tx_source_port;
    logic [15:0] tx_dest_port;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_last;
    logic        rx_ready;
    logic [7:0]  rx_data_out;
    logic        rx_data_valid;
    logic        rx_data_last;
    logic        rx_data_ready;
    logic [7:0]  tx_data;
    logic        tx_data_valid;
    logic        tx_data_last;
    logic        tx_data_ready;
    logic [7:0]  tx_out;
    logic        tx_valid;
    logic        tx_last;
    logic        tx_ready;

    // Bit 8 of each entry is the last flag
    logic [8:0]  rx_stim[$];
    logic [8:0]  rx_exp[$];
    logic [8:0]  tx_stim[$];
    logic [8:0]  tx_exp[$];
    int          checks = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          cycle_limit = 0;
    int          cycles;
    bit          load_ok;

    udp_connection i_dut (.*);

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          rc;
        int          n;
        int          i;
        logic [31:0] val;
        logic [8:0]  entry;
        string       key;
        string       rest;
        ok = 1'b0;
        fd = $fopen("test/udp_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/udp_stimulus.txt");
            return;
        end
        ok = 1'b1;
        while ($fscanf(fd, "%s", key) == 1) begin
            if (key.substr(0, 0) == "#") begin
                rc = $fgets(rest, fd);
            end else if (key == "cfg") begin
                rc = $fscanf(fd, "%h %h %h", rx_dest_port, tx_source_port, tx_dest_port);
            end else begin
                rc = $fscanf(fd, "%d", n);
                for (i = 0; i < n; i++) begin
                    rc = $fscanf(fd, "%h", val);
                    entry = {i == n - 1, val[7:0]};
                    if (key == "rx") begin
                        rx_stim.push_back(entry);
                    end else if (key == "rx_exp") begin
                        rx_exp.push_back(entry);
                    end else if (key == "tx") begin
                        tx_stim.push_back(entry);
                    end else if (key == "tx_exp") begin
                        tx_exp.push_back(entry);
                    end else begin
                        $display("Unknown record type %s in the stimulus file", key);
                        ok = 1'b0;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_rx;
        int i;
        for (i = 0; i < rx_stim.size(); i++) begin
            rx_data  <= rx_stim[i][7:0];
            rx_last  <= rx_stim[i][8];
            rx_valid <= 1'b1;
            @(posedge clk);
            while (!rx_ready) begin
                @(posedge clk);
            end
        end
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
    endtask

    task automatic drive_tx;
        int i;
        for (i = 0; i < tx_stim.size(); i++) begin
            tx_data       <= tx_stim[i][7:0];
            tx_data_last  <= tx_stim[i][8];
            tx_data_valid <= 1'b1;
            @(posedge clk);
            while (!tx_data_ready) begin
                @(posedge clk);
            end
        end
        tx_data_valid <= 1'b0;
        tx_data_last  <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Random back-pressure on both output streams
    initial begin
        forever begin
            @(posedge clk);
            rx_data_ready <= ($urandom % 4) != 0;
            tx_ready      <= ($urandom % 4) != 0;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (!rst && rx_data_valid && rx_data_ready) begin
                if (rx_exp.size() == 0) begin
                    other_errors++;
                    $display("Unexpected RX output byte %h at %0t", rx_data_out, $time);
                end else begin
                    check_value({rx_data_last, rx_data_out}, rx_exp.pop_front(), "RX byte");
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (!rst && tx_valid && tx_ready) begin
                if (tx_exp.size() == 0) begin
                    other_errors++;
                    $display("Unexpected TX output byte %h at %0t", tx_out, $time);
                end else begin
                    check_value({tx_last, tx_out}, tx_exp.pop_front(), "TX byte");
                end
            end
        end
    end

    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with output bytes still missing", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h3c40));
        rst            = 1'b1;
        rx_dest_port   = '0;
        tx_source_port = '0;
        tx_dest_port   = '0;
        rx_data        = '0;
        rx_valid       = 1'b0;
        rx_last        = 1'b0;
        rx_data_ready  = 1'b0;
        tx_data        = '0;
        tx_data_valid  = 1'b0;
        tx_data_last   = 1'b0;
        tx_ready       = 1'b0;
        load_stimulus(load_ok);
        cycle_limit = 20 * (rx_stim.size() + tx_stim.size()) + 200;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        if (load_ok) begin
            fork
                drive_rx();
                drive_tx();
            join
            while (rx_exp.size() != 0 || tx_exp.size() != 0) begin
                @(posedge clk);
            end
            // Room for stray extra bytes to show up
            repeat (20) @(posedge clk);
        end else begin
            other_errors++;
        end
        $display("Checks: %0d, value mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0 && checks > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/udp_pkg.sv
rtl/byte_fifo.sv
rtl/udp_rx_filter.sv
rtl/tx_frame_buffer.sv
rtl/udp_tx_framer.sv
rtl/udp_connection.sv
test/tb_udp_connection.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_udp_connection -f src.f

out=$(./obj_dir/Vtb_udp_connection)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST PASSED"

/* test/udp_stimulus.txt */
# cfg <rx_dest_port> <tx_source_port> <tx_dest_port>, all hex
# rx|tx|rx_exp|tx_exp <byte count, decimal> <bytes, hex>; rx_exp 0 marks a dropped datagram
cfg 1234 04d2 162e
# Matching port
rx 12 00 35 12 34 00 0c 00 00 de ad be ef
rx_exp 4 de ad be ef
# Other port
rx 11 00 35 12 35 00 0b 00 00 aa bb cc
rx_exp 0
# Port bytes swapped
rx 10 00 35 34 12 00 0a 00 00 01 02
rx_exp 0
# Ends inside the header
rx 5 00 35 12 34 00
rx_exp 0
rx 15 00 07 12 34 00 0f 00 00 10 11 12 13 14 15 16
rx_exp 7 10 11 12 13 14 15 16
rx 9 00 01 12 34 00 09 00 00 5a
rx_exp 1 5a
# TX frames written back to back
tx 4 01 02 03 04
tx_exp 12 04 d2 16 2e 00 0c 00 00 01 02 03 04
tx 1 ff
tx_exp 9 04 d2 16 2e 00 09 00 00 ff
tx 6 a0 a1 a2 a3 a4 a5
tx_exp 14 04 d2 16 2e 00 0e 00 00 a0 a1 a2 a3 a4 a5
tx 3 c3 3c 77
tx_exp 11 04 d2 16 2e 00 0b 00 00 c3 3c 77
